/* hw/soc_pkg.sv */
`default_nettype none

package soc_pkg;

	// One bus access as seen by a slave
	typedef struct packed {
		logic        rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_e;

	typedef enum logic [1:0] {
		PORT_A,
		PORT_B,
		PORT_C
	} arb_port_e;

	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_READ,
		DMA_WRITE
	} dma_state_e;

	// Memory map, address bits 31..28
	localparam logic [3:0] REGION_RAM   = 4'h1;
	localparam logic [3:0] REGION_DMA   = 4'h9;
	localparam logic [3:0] REGION_TIMER = 4'hA;

	localparam int RAM_WORDS     = 1024;
	localparam int RAM_ADDR_BITS = $clog2(RAM_WORDS);

	localparam logic [2:0] TIMER_REG_COUNT   = 3'd0;
	localparam logic [2:0] TIMER_REG_COMPARE = 3'd1;
	localparam logic [2:0] TIMER_REG_CONTROL = 3'd2;

	localparam logic [1:0] DMA_REG_SOURCE = 2'd0;
	localparam logic [1:0] DMA_REG_DEST   = 2'd1;
	localparam logic [1:0] DMA_REG_COUNT  = 2'd2;
	localparam logic [1:0] DMA_REG_STATUS = 2'd3;

endpackage

`default_nettype wire

/* hw/bus_access.sv */
`default_nettype none

module bus_access
	import soc_pkg::*;
(
	input  wire             clock,
	input  wire             i_reset,

	// Port A (instruction fetch)
	input  wire             i_pa_request,
	input  wire      [31:0] i_pa_address,
	output logic            o_pa_ready,
	output logic     [31:0] o_pa_rdata,

	// Port B (data)
	input  wire             i_pb_request,
	input  wire bus_req_t   i_pb_req,
	output logic            o_pb_ready,
	output logic     [31:0] o_pb_rdata,

	// Port C (DMA)
	input  wire             i_pc_request,
	input  wire bus_req_t   i_pc_req,
	output logic            o_pc_ready,
	output logic     [31:0] o_pc_rdata,

	// Shared bus
	output logic            o_bus_request,
	output bus_req_t        o_bus_req,
	input  wire             i_bus_ready,
	input  wire      [31:0] i_bus_rdata
);

	arb_state_e state;
	arb_port_e  grant;

	logic      pick_valid;
	arb_port_e pick_port;
	bus_req_t  pick_req;
	logic      bus_done;

	// Fixed priority, A over B over C
	always_comb
	begin
		pick_valid = 1'b1;
		pick_port  = PORT_A;
		pick_req   = '{rw: 1'b0, address: i_pa_address, wdata: 32'h0};
		if (i_pa_request)
		begin
			pick_port = PORT_A;
		end
		else if (i_pb_request)
		begin
			pick_port = PORT_B;
			pick_req  = i_pb_req;
		end
		else if (i_pc_request)
		begin
			pick_port = PORT_C;
			pick_req  = i_pc_req;
		end
		else
			pick_valid = 1'b0;
	end

	assign bus_done = (state == ARB_BUSY) && i_bus_ready;

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			state         <= ARB_IDLE;
			grant         <= PORT_A;
			o_bus_request <= 1'b0;
		end
		else if (state == ARB_IDLE)
		begin
			if (pick_valid)
			begin
				state         <= ARB_BUSY;
				grant         <= pick_port;
				o_bus_request <= 1'b1;
			end
		end
		else if (i_bus_ready)
		begin
			// Back to idle for one cycle
			state         <= ARB_IDLE;
			o_bus_request <= 1'b0;
		end
	end

	// Fields stay frozen while busy
	always_ff @(posedge clock)
	begin
		if (state == ARB_IDLE && pick_valid)
			o_bus_req <= pick_req;
	end

	//==================================================

	assign o_pa_ready = bus_done && (grant == PORT_A);
	assign o_pb_ready = bus_done && (grant == PORT_B);
	assign o_pc_ready = bus_done && (grant == PORT_C);

	assign o_pa_rdata = (grant == PORT_A) ? i_bus_rdata : 32'h0;
	assign o_pb_rdata = (grant == PORT_B) ? i_bus_rdata : 32'h0;
	assign o_pc_rdata = (grant == PORT_C) ? i_bus_rdata : 32'h0;

endmodule

`default_nettype wire

/* hw/bus_decode.sv */
`default_nettype none

module bus_decode
	import soc_pkg::*;
(
	input  wire             clock,
	input  wire             i_reset,
	input  wire             i_bus_request,
	input  wire bus_req_t   i_bus_req,
	output logic            o_bus_ready,
	output logic     [31:0] o_bus_rdata,

	// Slave selects
	output logic            o_ram_request,
	output logic            o_timer_request,
	output logic            o_dma_request,

	// Slave returns
	input  wire             i_ram_ready,
	input  wire      [31:0] i_ram_rdata,
	input  wire             i_timer_ready,
	input  wire      [31:0] i_timer_rdata,
	input  wire             i_dma_ready,
	input  wire      [31:0] i_dma_rdata
);

	logic [3:0] region;
	logic       sel_ram;
	logic       sel_timer;
	logic       sel_dma;
	logic       sel_none;
	logic       none_ready;

	assign region    = i_bus_req.address[31:28];
	assign sel_ram   = (region == REGION_RAM);
	assign sel_timer = (region == REGION_TIMER);
	assign sel_dma   = (region == REGION_DMA);
	assign sel_none  = !(sel_ram || sel_timer || sel_dma);

	assign o_ram_request   = i_bus_request && sel_ram;
	assign o_timer_request = i_bus_request && sel_timer;
	assign o_dma_request   = i_bus_request && sel_dma;

	// Unmapped responder, acks with zero data
	always_ff @(posedge clock)
	begin
		if (i_reset)
			none_ready <= 1'b0;
		else
			none_ready <= i_bus_request && sel_none && !none_ready;
	end

	always_comb
	begin
		o_bus_ready = none_ready;
		o_bus_rdata = 32'h0;
		if (sel_ram)
		begin
			o_bus_ready = i_ram_ready;
			o_bus_rdata = i_ram_rdata;
		end
		else if (sel_timer)
		begin
			o_bus_ready = i_timer_ready;
			o_bus_rdata = i_timer_rdata;
		end
		else if (sel_dma)
		begin
			o_bus_ready = i_dma_ready;
			o_bus_rdata = i_dma_rdata;
		end
	end

endmodule

`default_nettype wire

/* hw/bus_ram.sv */
`default_nettype none

module bus_ram
	import soc_pkg::*;
(
	input  wire             clock,
	input  wire             i_request,
	input  wire bus_req_t   i_bus_req,
	output logic            o_ready,
	output logic     [31:0] o_rdata
);

	logic [31:0] mem [RAM_WORDS];

	logic [RAM_ADDR_BITS-1:0] index;
	logic                     access;

	// Word index from address bits 11..2
	assign index  = i_bus_req.address[RAM_ADDR_BITS+1:2];
	assign access = i_request && !o_ready;

	always_ff @(posedge clock)
	begin
		if (access && i_bus_req.rw)
			mem[index] <= i_bus_req.wdata;
	end

	always_ff @(posedge clock)
	begin
		if (access)
			o_rdata <= mem[index];
	end

	// One-cycle ready pulse with the read data
	always_ff @(posedge clock)
	begin
		o_ready <= access;
	end

endmodule

`default_nettype wire

/* hw/bus_timer.sv */
`default_nettype none

module bus_timer
	import soc_pkg::*;
(
	input  wire             clock,
	input  wire             i_reset,
	input  wire             i_request,
	input  wire bus_req_t   i_bus_req,
	output logic            o_ready,
	output logic     [31:0] o_rdata,
	output logic            o_interrupt
);

	logic [31:0] counter;
	logic [31:0] compare;
	logic [31:0] control;
	logic [2:0]  reg_index;
	logic        access;
	logic        reg_write;

	assign reg_index = i_bus_req.address[4:2];
	assign access    = i_request && !o_ready;
	assign reg_write = access && i_bus_req.rw;

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			counter <= 32'h0;
			compare <= 32'h0;
			control <= 32'h0;
		end
		else
		begin
			if (reg_write && reg_index == TIMER_REG_COUNT)
				counter <= i_bus_req.wdata;
			else
				counter <= counter + 32'd1;
			if (reg_write && reg_index == TIMER_REG_COMPARE)
				compare <= i_bus_req.wdata;
			if (reg_write && reg_index == TIMER_REG_CONTROL)
				control <= i_bus_req.wdata;
		end
	end

	always_ff @(posedge clock)
	begin
		if (i_reset)
			o_ready <= 1'b0;
		else
			o_ready <= access;
	end

	always_ff @(posedge clock)
	begin
		if (access)
		begin
			case (reg_index)
				TIMER_REG_COUNT:   o_rdata <= counter;
				TIMER_REG_COMPARE: o_rdata <= compare;
				TIMER_REG_CONTROL: o_rdata <= control;
				default:           o_rdata <= 32'h0;
			endcase
		end
	end

	// Level interrupt, enabled by control bit 0
	assign o_interrupt = control[0] && (counter >= compare);

endmodule

`default_nettype wire

/* hw/bus_dma.sv */
`default_nettype none

module bus_dma
	import soc_pkg::*;
(
	input  wire             clock,
	input  wire             i_reset,

	// Register port
	input  wire             i_request,
	input  wire bus_req_t   i_bus_req,
	output logic            o_ready,
	output logic     [31:0] o_rdata,

	// Master port
	output logic            o_master_request,
	output bus_req_t        o_master_req,
	input  wire             i_master_ready,
	input  wire      [31:0] i_master_rdata
);

	dma_state_e state;

	logic [31:0] reg_source;
	logic [31:0] reg_dest;
	logic [31:0] reg_count;
	logic [31:0] src_ptr;
	logic [31:0] dst_ptr;
	logic [31:0] remaining;
	logic [31:0] data_word;
	logic [1:0]  reg_index;
	logic        access;
	logic        reg_write;
	logic        start;

	assign reg_index = i_bus_req.address[3:2];
	assign access    = i_request && !o_ready;
	assign reg_write = access && i_bus_req.rw;

	// Start is ignored while busy or with nothing to copy
	assign start = reg_write && (reg_index == DMA_REG_STATUS) && i_bus_req.wdata[0] &&
		(state == DMA_IDLE) && (reg_count != 32'h0);

	//==================================================

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			o_ready    <= 1'b0;
			reg_source <= 32'h0;
			reg_dest   <= 32'h0;
			reg_count  <= 32'h0;
		end
		else
		begin
			o_ready <= access;
			if (reg_write && reg_index == DMA_REG_SOURCE)
				reg_source <= i_bus_req.wdata;
			if (reg_write && reg_index == DMA_REG_DEST)
				reg_dest <= i_bus_req.wdata;
			if (reg_write && reg_index == DMA_REG_COUNT)
				reg_count <= i_bus_req.wdata;
		end
	end

	always_ff @(posedge clock)
	begin
		if (access)
		begin
			case (reg_index)
				DMA_REG_SOURCE: o_rdata <= reg_source;
				DMA_REG_DEST:   o_rdata <= reg_dest;
				DMA_REG_COUNT:  o_rdata <= reg_count;
				default:        o_rdata <= {31'h0, state != DMA_IDLE};
			endcase
		end
	end

	//==================================================

	always_ff @(posedge clock)
	begin
		if (i_reset)
			state <= DMA_IDLE;
		else
		begin
			case (state)
				DMA_IDLE:  if (start) state <= DMA_READ;
				DMA_READ:  if (i_master_ready) state <= DMA_WRITE;
				DMA_WRITE:
				begin
					if (i_master_ready)
						state <= (remaining == 32'd1) ? DMA_IDLE : DMA_READ;
				end
				default:   state <= DMA_IDLE;
			endcase
		end
	end

	// Working copies, the programmed registers stay readable
	always_ff @(posedge clock)
	begin
		if (start)
		begin
			src_ptr   <= reg_source;
			dst_ptr   <= reg_dest;
			remaining <= reg_count;
		end
		if (state == DMA_READ && i_master_ready)
			data_word <= i_master_rdata;
		if (state == DMA_WRITE && i_master_ready)
		begin
			src_ptr   <= src_ptr + 32'd4;
			dst_ptr   <= dst_ptr + 32'd4;
			remaining <= remaining - 32'd1;
		end
	end

	assign o_master_request = (state != DMA_IDLE);

	always_comb
	begin
		o_master_req.rw      = (state == DMA_WRITE);
		o_master_req.address = (state == DMA_WRITE) ? dst_ptr : src_ptr;
		o_master_req.wdata   = data_word;
	end

endmodule

`default_nettype wire

/* hw/soc_fabric.sv */
`default_nettype none

module soc_fabric
	import soc_pkg::*;
(
	input  wire             clock,
	input  wire             i_reset,

	input  wire             i_pa_request,
	input  wire      [31:0] i_pa_address,
	output logic            o_pa_ready,
	output logic     [31:0] o_pa_rdata,

	input  wire             i_pb_request,
	input  wire bus_req_t   i_pb_req,
	output logic            o_pb_ready,
	output logic     [31:0] o_pb_rdata,

	output logic            o_timer_interrupt
);

	// Shared bus
	logic        bus_request;
	bus_req_t    bus_req;
	logic        bus_ready;
	logic [31:0] bus_rdata;

	// Slaves
	logic        ram_request;
	logic        ram_ready;
	logic [31:0] ram_rdata;
	logic        timer_request;
	logic        timer_ready;
	logic [31:0] timer_rdata;
	logic        dma_request;
	logic        dma_ready;
	logic [31:0] dma_rdata;

	// DMA master side on port C
	logic        pc_request;
	bus_req_t    pc_req;
	logic        pc_ready;
	logic [31:0] pc_rdata;

	bus_access u_access (
		.clock, .i_reset,
		.i_pa_request, .i_pa_address, .o_pa_ready, .o_pa_rdata,
		.i_pb_request, .i_pb_req, .o_pb_ready, .o_pb_rdata,
		.i_pc_request(pc_request), .i_pc_req(pc_req),
		.o_pc_ready(pc_ready), .o_pc_rdata(pc_rdata),
		.o_bus_request(bus_request), .o_bus_req(bus_req),
		.i_bus_ready(bus_ready), .i_bus_rdata(bus_rdata)
	);

	bus_decode u_decode (
		.clock, .i_reset,
		.i_bus_request(bus_request), .i_bus_req(bus_req),
		.o_bus_ready(bus_ready), .o_bus_rdata(bus_rdata),
		.o_ram_request(ram_request), .o_timer_request(timer_request),
		.o_dma_request(dma_request),
		.i_ram_ready(ram_ready), .i_ram_rdata(ram_rdata),
		.i_timer_ready(timer_ready), .i_timer_rdata(timer_rdata),
		.i_dma_ready(dma_ready), .i_dma_rdata(dma_rdata)
	);

	bus_ram u_ram (
		.clock, .i_request(ram_request), .i_bus_req(bus_req),
		.o_ready(ram_ready), .o_rdata(ram_rdata)
	);

	bus_timer u_timer (
		.clock, .i_reset, .i_request(timer_request), .i_bus_req(bus_req),
		.o_ready(timer_ready), .o_rdata(timer_rdata), .o_interrupt(o_timer_interrupt)
	);

	bus_dma u_dma (
		.clock, .i_reset, .i_request(dma_request), .i_bus_req(bus_req),
		.o_ready(dma_ready), .o_rdata(dma_rdata),
		.o_master_request(pc_request), .o_master_req(pc_req),
		.i_master_ready(pc_ready), .i_master_rdata(pc_rdata)
	);

endmodule

`default_nettype wire

/* dv/tb_soc_fabric.sv */
`default_nettype none

module tb_soc_fabric
	import soc_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// Tests take about 3000 cycles
	localparam int TIMEOUT_CYCLES = 20000;

	logic        clock;
	logic        reset;
	logic        pa_request;
	logic [31:0] pa_address;
	logic        pa_ready;
	logic [31:0] pa_rdata;
	logic        pb_request;
	bus_req_t    pb_req;
	logic        pb_ready;
	logic [31:0] pb_rdata;
	logic        timer_interrupt;

	// Reference model state
	logic [31:0] ram_model [RAM_WORDS];
	logic [31:0] compare_model = 32'h0;
	logic [31:0] control_model = 32'h0;
	logic [31:0] source_model = 32'h0;
	logic [31:0] dest_model = 32'h0;
	logic [31:0] count_model = 32'h0;
	logic        dma_busy_model = 1'b0;

	logic [31:0] got_q [$];
	logic [31:0] exp_q [$];
	string       name_q [$];

	logic [31:0] rng_state = 32'h8397;
	int          cycle_count = 0;
	int          pa_request_count = 0;
	int          pb_request_count = 0;
	int          pa_ready_count = 0;
	int          pb_ready_count = 0;
	logic        fetch_stop = 1'b0;

	soc_fabric u_dut (
		.clock, .i_reset(reset),
		.i_pa_request(pa_request), .i_pa_address(pa_address),
		.o_pa_ready(pa_ready), .o_pa_rdata(pa_rdata),
		.i_pb_request(pb_request), .i_pb_req(pb_req),
		.o_pb_ready(pb_ready), .o_pb_rdata(pb_rdata),
		.o_timer_interrupt(timer_interrupt)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	//==================================================

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [31:0] ram_addr(input int idx);
		return {REGION_RAM, 16'h0, idx[9:0], 2'b00};
	endfunction

	function automatic logic [31:0] timer_addr(input logic [2:0] idx);
		return {REGION_TIMER, 23'h0, idx, 2'b00};
	endfunction

	function automatic logic [31:0] dma_addr(input logic [1:0] idx);
		return {REGION_DMA, 24'h0, idx, 2'b00};
	endfunction

	// Expected read data for any address
	function automatic logic [31:0] ref_read(input logic [31:0] addr);
		logic [31:0] value;
		value = 32'h0;
		case (addr[31:28])
			REGION_RAM: value = ram_model[addr[11:2]];
			REGION_TIMER:
			begin
				if (addr[4:2] == TIMER_REG_COMPARE)
					value = compare_model;
				else if (addr[4:2] == TIMER_REG_CONTROL)
					value = control_model;
			end
			REGION_DMA:
			begin
				case (addr[3:2])
					DMA_REG_SOURCE: value = source_model;
					DMA_REG_DEST:   value = dest_model;
					DMA_REG_COUNT:  value = count_model;
					default:        value = {31'h0, dma_busy_model};
				endcase
			end
			default: value = 32'h0;
		endcase
		return value;
	endfunction

	function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] src_word;
		logic [31:0] dst_word;
		case (addr[31:28])
			REGION_RAM: ram_model[addr[11:2]] = data;
			REGION_TIMER:
			begin
				if (addr[4:2] == TIMER_REG_COMPARE)
					compare_model = data;
				else if (addr[4:2] == TIMER_REG_CONTROL)
					control_model = data;
			end
			REGION_DMA:
			begin
				case (addr[3:2])
					DMA_REG_SOURCE: source_model = data;
					DMA_REG_DEST:   dest_model = data;
					DMA_REG_COUNT:  count_model = data;
					default:
					begin
						// Word copy, both pointers step by 4
						if (data[0] && !dma_busy_model && count_model != 32'h0)
						begin
							for (int i = 0; i < count_model; i++)
							begin
								src_word = source_model + (i << 2);
								dst_word = dest_model + (i << 2);
								ram_model[dst_word[11:2]] = ram_model[src_word[11:2]];
							end
							dma_busy_model = 1'b1;
						end
					end
				endcase
			end
			default: ;
		endcase
	endfunction

	function automatic void push_result(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		name_q.push_back(name);
		got_q.push_back(got);
		exp_q.push_back(expected);
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	//==================================================

	task automatic pa_fetch(input logic [31:0] addr);
		@(posedge clock);
		pa_request <= 1'b1;
		pa_address <= addr;
		pa_request_count++;
		@(negedge clock);
		while (!pa_ready)
			@(negedge clock);
		push_result("o_pa_rdata", pa_rdata, ref_read(addr));
		@(posedge clock);
		pa_request <= 1'b0;
	endtask

	task automatic pb_access(input logic rw, input logic [31:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output int cycles);
		bus_req_t req;
		req.rw = rw;
		req.address = addr;
		req.wdata = wdata;
		@(posedge clock);
		pb_request <= 1'b1;
		pb_req <= req;
		pb_request_count++;
		cycles = 0;
		@(negedge clock);
		while (!pb_ready)
		begin
			cycles++;
			@(negedge clock);
		end
		rdata = pb_rdata;
		if (rw)
			model_write(addr, wdata);
		@(posedge clock);
		pb_request <= 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		int cycles;
		pb_access(1'b1, addr, data, rd, cycles);
	endtask

	task automatic bus_read(input logic [31:0] addr);
		logic [31:0] rd;
		int cycles;
		pb_access(1'b0, addr, 32'h0, rd, cycles);
		push_result("o_pb_rdata", rd, ref_read(addr));
	endtask

	task automatic fill_words(input int first, input int count);
		for (int k = 0; k < count; k++)
			bus_write(ram_addr(first + k), next_random());
	endtask

	// Instruction fetches from words 512..575 until stopped
	task automatic fetch_loop();
		while (!fetch_stop)
		begin
			repeat (next_random() % 4)
				@(posedge clock);
			pa_fetch(ram_addr(512 + next_random() % 64));
		end
	endtask

	//==================================================

	always @(posedge clock)
	begin
		while (got_q.size() > 0)
			check_value(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
	end

	always @(negedge clock)
	begin
		if (!reset && pa_ready)
			pa_ready_count++;
		if (!reset && pb_ready)
			pb_ready_count++;
	end

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Error at %0t ns: the run timed out after %0d cycles", $time, cycle_count);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		logic [31:0] rd;
		logic [31:0] r;
		int cycles;
		int waited;

		reset = 1'b1;
		pa_request = 1'b0;
		pa_address = 32'h0;
		pb_request = 1'b0;
		pb_req = '0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;

		fill_words(0, 64);
		fill_words(512, 64);

		// Uncontested write and read back
		pb_access(1'b1, ram_addr(70), next_random(), rd, cycles);
		check_value("o_pb_ready latency", cycles, 2);
		pb_access(1'b0, ram_addr(70), 32'h0, rd, cycles);
		check_value("o_pb_ready latency", cycles, 2);
		push_result("o_pb_rdata", rd, ref_read(ram_addr(70)));

		// Port B traffic against port A fetches
		fork
			fetch_loop();
			begin
				for (int n = 0; n < 200; n++)
				begin
					r = next_random();
					if (r[8])
						bus_write(ram_addr(r[5:0]), next_random());
					else
						bus_read(ram_addr(r[5:0]));
				end
				fetch_stop = 1'b1;
			end
		join
		check_value("o_pa_ready count", pa_ready_count, pa_request_count);
		check_value("o_pb_ready count", pb_ready_count, pb_request_count);

		bus_read(32'h0000_0040);
		bus_read(32'h2000_0000);
		bus_read(32'hF000_1230);

		// Timer
		bus_write(timer_addr(TIMER_REG_COMPARE), 32'hFFFF_FFFF);
		bus_write(timer_addr(TIMER_REG_CONTROL), 32'h1);
		bus_write(timer_addr(TIMER_REG_COUNT), 32'h0);
		bus_write(timer_addr(TIMER_REG_COMPARE), 32'd64);
		@(negedge clock);
		check_value("o_timer_interrupt", timer_interrupt, 32'h0);
		waited = 0;
		while (!timer_interrupt && waited < 100)
		begin
			@(negedge clock);
			waited++;
		end
		check_value("o_timer_interrupt", timer_interrupt, 32'h1);
		bus_write(timer_addr(TIMER_REG_COMPARE), 32'hFFFF_FFFF);
		@(negedge clock);
		check_value("o_timer_interrupt", timer_interrupt, 32'h0);
		bus_read(timer_addr(TIMER_REG_COMPARE));
		bus_read(timer_addr(TIMER_REG_CONTROL));
		bus_write(timer_addr(TIMER_REG_CONTROL), 32'h0000_5A50);
		bus_write(timer_addr(TIMER_REG_COMPARE), 32'h0);
		repeat (20)
		begin
			@(negedge clock);
			check_value("o_timer_interrupt", timer_interrupt, 32'h0);
		end
		bus_read(timer_addr(TIMER_REG_COMPARE));
		bus_read(timer_addr(TIMER_REG_CONTROL));

		// DMA copy of words 0..15 to 32..47, words 16..31 must stay put
		fill_words(0, 32);
		fetch_stop = 1'b0;
		fork
			fetch_loop();
			begin
				bus_write(dma_addr(DMA_REG_SOURCE), ram_addr(0));
				bus_write(dma_addr(DMA_REG_DEST), ram_addr(32));
				bus_write(dma_addr(DMA_REG_COUNT), 32'd16);
				bus_read(dma_addr(DMA_REG_SOURCE));
				bus_read(dma_addr(DMA_REG_DEST));
				bus_read(dma_addr(DMA_REG_COUNT));
				bus_write(dma_addr(DMA_REG_STATUS), 32'h1);
				bus_write(dma_addr(DMA_REG_DEST), ram_addr(16));
				bus_write(dma_addr(DMA_REG_STATUS), 32'h1);
				bus_read(dma_addr(DMA_REG_STATUS));
				do
				begin
					repeat (4) @(posedge clock);
					pb_access(1'b0, dma_addr(DMA_REG_STATUS), 32'h0, rd, cycles);
				end
				while (rd[0]);
				dma_busy_model = 1'b0;
				bus_read(dma_addr(DMA_REG_STATUS));
				fetch_stop = 1'b1;
			end
		join
		for (int k = 0; k < 48; k++)
			bus_read(ram_addr(k));
		check_value("o_pa_ready count", pa_ready_count, pa_request_count);
		check_value("o_pb_ready count", pb_ready_count, pb_request_count);

		repeat (2) @(posedge clock);
		if (got_q.size() != 0)
		begin
			$display("Error at %0t ns: %0d read results were never compared", $time, got_q.size());
			$display("Simulation failed");
			$fatal(1, "results left unchecked");
		end
		else
		begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* vlog.f */
hw/soc_pkg.sv
hw/bus_access.sv
hw/bus_decode.sv
hw/bus_ram.sv
hw/bus_timer.sv
hw/bus_dma.sv
hw/soc_fabric.sv
dv/tb_soc_fabric.sv
